/* common/tomasulo_settings.svh */
`ifndef TOMASULO_SETTINGS_SVH
`define TOMASULO_SETTINGS_SVH

// reorder buffer entries, a power of two
`define ROB_DEPTH 8

// entries in each reservation station
`define RS_DEPTH 4

// datapath width
`define XLEN 32

`endif

/* common/tomasulo_pkg.sv */
`include "tomasulo_settings.svh"

package tomasulo_pkg;

    // tag width follows the reorder buffer depth
    localparam int ROB_TAG_W = $clog2(`ROB_DEPTH);

    typedef logic [ROB_TAG_W-1:0] rob_tag_t;

    // major opcodes, register and immediate forms
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

endpackage

/* rs/alu.sv */
`timescale 1ns/10ps
`include "tomasulo_settings.svh"

module alu (
    input  tomasulo_pkg::alu_op_e alu_op_i,
    input  logic [`XLEN-1:0]      a_i,
    input  logic [`XLEN-1:0]      b_i,
    output logic [`XLEN-1:0]      result_o
);
    import tomasulo_pkg::*;

    logic [4:0] shamt;

    assign shamt = b_i[4:0];

    always_comb begin
        case (alu_op_i)
            ALU_ADD:  result_o = a_i + b_i;
            ALU_SUB:  result_o = a_i - b_i;
            ALU_SLL:  result_o = a_i << shamt;
            ALU_SLT:  result_o = `XLEN'($signed(a_i) < $signed(b_i));
            ALU_SLTU: result_o = `XLEN'(a_i < b_i);
            ALU_XOR:  result_o = a_i ^ b_i;
            ALU_SRL:  result_o = a_i >> shamt;
            // arithmetic shift keeps the sign
            ALU_SRA:  result_o = `XLEN'($signed(a_i) >>> shamt);
            ALU_OR:   result_o = a_i | b_i;
            default:  result_o = a_i & b_i;
        endcase
    end

endmodule

/* rs/reservation_station.sv */
`timescale 1ns/10ps
`include "tomasulo_settings.svh"

module reservation_station (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   load_i,
    input  tomasulo_pkg::alu_op_e  alu_op_i,
    input  logic                   op_a_ready_i,
    input  logic [`XLEN-1:0]       op_a_value_i,
    input  tomasulo_pkg::rob_tag_t op_a_tag_i,
    input  logic                   op_b_ready_i,
    input  logic [`XLEN-1:0]       op_b_value_i,
    input  tomasulo_pkg::rob_tag_t op_b_tag_i,
    input  tomasulo_pkg::rob_tag_t dest_tag_i,
    input  logic                   cdb_valid_i,
    input  tomasulo_pkg::rob_tag_t cdb_tag_i,
    input  logic [`XLEN-1:0]       cdb_data_i,
    input  logic                   cdb_grant_i,
    output logic                   full_o,
    output logic                   cdb_req_o,
    output tomasulo_pkg::rob_tag_t result_tag_o,
    output logic [`XLEN-1:0]       result_data_o
);
    import tomasulo_pkg::*;

    localparam int DEPTH = `RS_DEPTH;
    localparam int AGE_W = $clog2(DEPTH);

    logic [DEPTH-1:0] valid_q;
    logic [DEPTH-1:0] a_rdy_q;
    logic [DEPTH-1:0] b_rdy_q;
    alu_op_e          op_q    [DEPTH];
    logic [`XLEN-1:0] a_val_q [DEPTH];
    logic [`XLEN-1:0] b_val_q [DEPTH];
    rob_tag_t         a_tag_q [DEPTH];
    rob_tag_t         b_tag_q [DEPTH];
    rob_tag_t         dest_q  [DEPTH];
    // age counts the younger entries still held
    logic [AGE_W-1:0] age_q   [DEPTH];

    logic [DEPTH-1:0] ready;
    logic [AGE_W-1:0] sel_idx;
    logic [AGE_W-1:0] free_idx;
    logic             fire;
    logic             res_valid_q;
    rob_tag_t         res_tag_q;
    logic [`XLEN-1:0] res_data_q;
    logic [`XLEN-1:0] alu_result;

    assign ready  = valid_q & a_rdy_q & b_rdy_q;
    assign full_o = &valid_q;

    // oldest ready entry has the largest age
    always_comb begin
        sel_idx = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (ready[i] && (!ready[sel_idx] || age_q[i] > age_q[sel_idx]))
                sel_idx = AGE_W'(i);
        end
    end

    always_comb begin
        free_idx = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!valid_q[i])
                free_idx = AGE_W'(i);
        end
    end

    // result register frees up in its grant cycle
    assign fire = (|ready) && (!res_valid_q || cdb_grant_i);

    alu u_alu (
        .alu_op_i (op_q[sel_idx]),
        .a_i      (a_val_q[sel_idx]),
        .b_i      (b_val_q[sel_idx]),
        .result_o (alu_result)
    );

    //////////////////////////////////////////////////////////////////////
    // entry and result control
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q     <= '0;
            res_valid_q <= 1'b0;
        end else begin
            if (fire)
                valid_q[sel_idx] <= 1'b0;
            if (load_i)
                valid_q[free_idx] <= 1'b1;
            if (fire)
                res_valid_q <= 1'b1;
            else if (cdb_grant_i)
                res_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (cdb_valid_i && valid_q[i] && !a_rdy_q[i] && a_tag_q[i] == cdb_tag_i) begin
                a_rdy_q[i] <= 1'b1;
                a_val_q[i] <= cdb_data_i;
            end
            if (cdb_valid_i && valid_q[i] && !b_rdy_q[i] && b_tag_q[i] == cdb_tag_i) begin
                b_rdy_q[i] <= 1'b1;
                b_val_q[i] <= cdb_data_i;
            end
            // older entries lose a younger one when it issues
            if (valid_q[i])
                age_q[i] <= age_q[i] + AGE_W'(load_i)
                            - AGE_W'(fire && age_q[i] > age_q[sel_idx]);
        end
        if (load_i) begin
            op_q[free_idx]    <= alu_op_i;
            a_rdy_q[free_idx] <= op_a_ready_i;
            a_val_q[free_idx] <= op_a_value_i;
            a_tag_q[free_idx] <= op_a_tag_i;
            b_rdy_q[free_idx] <= op_b_ready_i;
            b_val_q[free_idx] <= op_b_value_i;
            b_tag_q[free_idx] <= op_b_tag_i;
            dest_q[free_idx]  <= dest_tag_i;
            age_q[free_idx]   <= '0;
        end
        if (fire) begin
            res_tag_q  <= dest_q[sel_idx];
            res_data_q <= alu_result;
        end
    end

    assign cdb_req_o     = res_valid_q;
    assign result_tag_o  = res_tag_q;
    assign result_data_o = res_data_q;

    a_req_held: assert property (@(posedge clk) disable iff (reset_i)
        cdb_req_o && !cdb_grant_i |=> cdb_req_o && $stable(result_tag_o));

endmodule

/* rob/rob.sv */
`timescale 1ns/10ps
`include "tomasulo_settings.svh"

module rob (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   alloc_i,
    input  logic [4:0]             alloc_rd_i,
    input  logic                   cdb_valid_i,
    input  tomasulo_pkg::rob_tag_t cdb_tag_i,
    input  logic [`XLEN-1:0]       cdb_data_i,
    input  tomasulo_pkg::rob_tag_t lookup_tag_a_i,
    input  tomasulo_pkg::rob_tag_t lookup_tag_b_i,
    output tomasulo_pkg::rob_tag_t tail_tag_o,
    output logic                   full_o,
    output logic                   done_a_o,
    output logic [`XLEN-1:0]       value_a_o,
    output logic                   done_b_o,
    output logic [`XLEN-1:0]       value_b_o,
    output logic                   commit_valid_o,
    output tomasulo_pkg::rob_tag_t commit_tag_o,
    output logic [4:0]             commit_rd_o,
    output logic [`XLEN-1:0]       commit_data_o
);
    import tomasulo_pkg::*;

    localparam int DEPTH = `ROB_DEPTH;

    rob_tag_t           head_q;
    rob_tag_t           tail_q;
    logic [ROB_TAG_W:0] count_q;
    logic [DEPTH-1:0]   done_q;
    logic [4:0]         rd_q    [DEPTH];
    logic [`XLEN-1:0]   value_q [DEPTH];

    //////////////////////////////////////////////////////////////////////
    // pointers, count and done bits
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            done_q  <= '0;
        end else begin
            if (alloc_i) begin
                tail_q         <= tail_q + 1'b1;
                done_q[tail_q] <= 1'b0;
            end
            // broadcast marks the producing entry done
            if (cdb_valid_i)
                done_q[cdb_tag_i] <= 1'b1;
            if (commit_valid_o)
                head_q <= head_q + 1'b1;
            case ({alloc_i, commit_valid_o})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_i)
            rd_q[tail_q] <= alloc_rd_i;
        if (cdb_valid_i)
            value_q[cdb_tag_i] <= cdb_data_i;
    end

    assign tail_tag_o = tail_q;
    assign full_o     = (count_q == DEPTH[ROB_TAG_W:0]);

    // operand lookups for the register file
    assign done_a_o  = done_q[lookup_tag_a_i];
    assign value_a_o = value_q[lookup_tag_a_i];
    assign done_b_o  = done_q[lookup_tag_b_i];
    assign value_b_o = value_q[lookup_tag_b_i];

    // head retires once its result is in
    assign commit_valid_o = (count_q != '0) && done_q[head_q];
    assign commit_tag_o   = head_q;
    assign commit_rd_o    = rd_q[head_q];
    assign commit_data_o  = value_q[head_q];

    a_no_alloc_full: assert property (@(posedge clk) disable iff (reset_i)
        alloc_i |-> !full_o);

    a_commit_done: assert property (@(posedge clk) disable iff (reset_i)
        commit_valid_o |-> done_q[commit_tag_o]);

endmodule

/* src/regfile.sv */
`timescale 1ns/10ps
`include "tomasulo_settings.svh"

module regfile (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   rename_i,
    input  logic [4:0]             rename_rd_i,
    input  tomasulo_pkg::rob_tag_t rename_tag_i,
    input  logic [4:0]             rs1_i,
    input  logic [4:0]             rs2_i,
    input  logic                   use_imm_i,
    input  logic [`XLEN-1:0]       imm_i,
    input  logic                   rob_done_a_i,
    input  logic [`XLEN-1:0]       rob_value_a_i,
    input  logic                   rob_done_b_i,
    input  logic [`XLEN-1:0]       rob_value_b_i,
    input  logic                   cdb_valid_i,
    input  tomasulo_pkg::rob_tag_t cdb_tag_i,
    input  logic [`XLEN-1:0]       cdb_data_i,
    input  logic                   commit_valid_i,
    input  tomasulo_pkg::rob_tag_t commit_tag_i,
    input  logic [4:0]             commit_rd_i,
    input  logic [`XLEN-1:0]       commit_data_i,
    output tomasulo_pkg::rob_tag_t lookup_tag_a_o,
    output tomasulo_pkg::rob_tag_t lookup_tag_b_o,
    output logic                   op_a_ready_o,
    output logic [`XLEN-1:0]       op_a_value_o,
    output tomasulo_pkg::rob_tag_t op_a_tag_o,
    output logic                   op_b_ready_o,
    output logic [`XLEN-1:0]       op_b_value_o,
    output tomasulo_pkg::rob_tag_t op_b_tag_o
);
    import tomasulo_pkg::*;

    logic [`XLEN-1:0] regs_q [32];
    rob_tag_t         tag_q  [32];
    logic [31:0]      pending_q;
    logic [`XLEN:0]   op_b_res;

    // ready bit on top, value below; first matching source wins
    function automatic logic [`XLEN:0] resolve(
        input logic             pending,
        input rob_tag_t         tag,
        input logic [`XLEN-1:0] reg_value,
        input logic             rob_done,
        input logic [`XLEN-1:0] rob_value
    );
        if (!pending)
            return {1'b1, reg_value};
        else if (rob_done)
            return {1'b1, rob_value};
        else if (cdb_valid_i && cdb_tag_i == tag)
            return {1'b1, cdb_data_i};
        else
            return {1'b0, reg_value};
    endfunction

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pending_q <= '0;
            for (int i = 0; i < 32; i++) begin
                regs_q[i] <= '0;
                tag_q[i]  <= '0;
            end
        end else begin
            if (commit_valid_i && commit_rd_i != 5'd0) begin
                regs_q[commit_rd_i] <= commit_data_i;
                // only the newest producer clears the pending flag
                if (tag_q[commit_rd_i] == commit_tag_i)
                    pending_q[commit_rd_i] <= 1'b0;
            end
            // rename comes last so a same-cycle commit keeps the new tag
            if (rename_i && rename_rd_i != 5'd0) begin
                pending_q[rename_rd_i] <= 1'b1;
                tag_q[rename_rd_i]     <= rename_tag_i;
            end
        end
    end

    assign lookup_tag_a_o = tag_q[rs1_i];
    assign lookup_tag_b_o = tag_q[rs2_i];
    assign op_a_tag_o     = tag_q[rs1_i];
    assign op_b_tag_o     = tag_q[rs2_i];

    // bus signals read inside resolve must wake this block too
    always_comb begin
        {op_a_ready_o, op_a_value_o} = resolve(pending_q[rs1_i], tag_q[rs1_i],
                                               regs_q[rs1_i], rob_done_a_i, rob_value_a_i);
        op_b_res = resolve(pending_q[rs2_i], tag_q[rs2_i],
                           regs_q[rs2_i], rob_done_b_i, rob_value_b_i);
    end

    // immediate forms replace operand b
    assign op_b_ready_o = use_imm_i | op_b_res[`XLEN];
    assign op_b_value_o = use_imm_i ? imm_i : op_b_res[`XLEN-1:0];

endmodule

/* src/issue_decode.sv */
`timescale 1ns/10ps
`include "tomasulo_settings.svh"

module issue_decode (
    input  logic                  instr_valid_i,
    input  logic [31:0]           instr_i,
    input  logic                  rob_full_i,
    input  logic [1:0]            rs_full_i,
    output logic                  stall_o,
    output logic                  alloc_o,
    output logic                  rename_o,
    output logic [4:0]            rd_o,
    output logic [4:0]            rs1_o,
    output logic [4:0]            rs2_o,
    output logic                  use_imm_o,
    output logic [`XLEN-1:0]      imm_o,
    output tomasulo_pkg::alu_op_e alu_op_o,
    output logic [1:0]            load_o
);
    import tomasulo_pkg::*;

    opcode_e opcode;
    logic    rs_sel;
    logic    accept;

    assign opcode    = opcode_e'(instr_i[6:0]);
    assign rd_o      = instr_i[11:7];
    assign rs1_o     = instr_i[19:15];
    assign rs2_o     = instr_i[24:20];
    assign use_imm_o = (opcode == OPC_OP_IMM);
    assign imm_o     = {{(`XLEN-12){instr_i[31]}}, instr_i[31:20]};

    // bit 30 means SUB only for the register form, SRA/SRAI for both
    always_comb begin
        case (instr_i[14:12])
            3'b000:  alu_op_o = (opcode == OPC_OP && instr_i[30]) ? ALU_SUB : ALU_ADD;
            3'b001:  alu_op_o = ALU_SLL;
            3'b010:  alu_op_o = ALU_SLT;
            3'b011:  alu_op_o = ALU_SLTU;
            3'b100:  alu_op_o = ALU_XOR;
            3'b101:  alu_op_o = instr_i[30] ? ALU_SRA : ALU_SRL;
            3'b110:  alu_op_o = ALU_OR;
            default: alu_op_o = ALU_AND;
        endcase
    end

    // station 1 takes shifts and compares, station 0 the rest
    assign rs_sel = alu_op_o inside {ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU};

    assign stall_o  = rob_full_i | (instr_valid_i & rs_full_i[rs_sel]);
    assign accept   = instr_valid_i & ~stall_o;
    assign alloc_o  = accept;
    assign rename_o = accept & (rd_o != 5'd0);
    assign load_o   = {accept & rs_sel, accept & ~rs_sel};

    always_comb begin
        if (!$isunknown(stall_o))
            a_no_load_on_stall: assert (!(stall_o && (|load_o)));
    end

endmodule

/* src/cdb_arbiter.sv */
`timescale 1ns/10ps
`include "tomasulo_settings.svh"

module cdb_arbiter (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic [1:0]             req_i,
    input  tomasulo_pkg::rob_tag_t tag_a_i,
    input  logic [`XLEN-1:0]       data_a_i,
    input  tomasulo_pkg::rob_tag_t tag_b_i,
    input  logic [`XLEN-1:0]       data_b_i,
    output logic [1:0]             grant_o,
    output logic                   cdb_valid_o,
    output tomasulo_pkg::rob_tag_t cdb_tag_o,
    output logic [`XLEN-1:0]       cdb_data_o
);

    // station granted most recently
    logic last_q;

    // on a tie the other station wins
    always_comb begin
        if (&req_i)
            grant_o = last_q ? 2'b01 : 2'b10;
        else
            grant_o = req_i;
    end

    always_ff @(posedge clk) begin
        if (reset_i)
            last_q <= 1'b1;
        else if (|req_i)
            last_q <= grant_o[1];
    end

    assign cdb_valid_o = |req_i;
    assign cdb_tag_o   = grant_o[1] ? tag_b_i : tag_a_i;
    assign cdb_data_o  = grant_o[1] ? data_b_i : data_a_i;

    a_grant_onehot: assert property (@(posedge clk) disable iff (reset_i)
        $onehot0(grant_o));

endmodule

/* src/ooo_core.sv */
`timescale 1ns/10ps
`include "tomasulo_settings.svh"

module ooo_core (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               instr_valid_i,
    input  logic [31:0]        instr_i,
    output logic               stall_o,
    output logic               commit_valid_o,
    output logic [4:0]         commit_rd_o,
    output logic [`XLEN-1:0]   commit_data_o
);
    import tomasulo_pkg::*;

    logic             alloc;
    logic             rename;
    logic [4:0]       rd;
    logic [4:0]       rs1;
    logic [4:0]       rs2;
    logic             use_imm;
    logic [`XLEN-1:0] imm;
    alu_op_e          alu_op;
    logic [1:0]       rs_load;
    logic [1:0]       rs_full;
    logic             rob_full;
    rob_tag_t         tail_tag;
    rob_tag_t         commit_tag;

    // operand lookup path
    rob_tag_t         lookup_tag_a;
    rob_tag_t         lookup_tag_b;
    logic             rob_done_a;
    logic             rob_done_b;
    logic [`XLEN-1:0] rob_value_a;
    logic [`XLEN-1:0] rob_value_b;
    logic             op_a_ready;
    logic             op_b_ready;
    logic [`XLEN-1:0] op_a_value;
    logic [`XLEN-1:0] op_b_value;
    rob_tag_t         op_a_tag;
    rob_tag_t         op_b_tag;

    // common data bus
    logic [1:0]       cdb_req;
    logic [1:0]       cdb_grant;
    rob_tag_t         res_tag  [2];
    logic [`XLEN-1:0] res_data [2];
    logic             cdb_valid;
    rob_tag_t         cdb_tag;
    logic [`XLEN-1:0] cdb_data;

    issue_decode u_issue_decode (
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .rob_full_i    (rob_full),
        .rs_full_i     (rs_full),
        .stall_o       (stall_o),
        .alloc_o       (alloc),
        .rename_o      (rename),
        .rd_o          (rd),
        .rs1_o         (rs1),
        .rs2_o         (rs2),
        .use_imm_o     (use_imm),
        .imm_o         (imm),
        .alu_op_o      (alu_op),
        .load_o        (rs_load)
    );

    rob u_rob (
        .clk            (clk),
        .reset_i        (reset_i),
        .alloc_i        (alloc),
        .alloc_rd_i     (rd),
        .cdb_valid_i    (cdb_valid),
        .cdb_tag_i      (cdb_tag),
        .cdb_data_i     (cdb_data),
        .lookup_tag_a_i (lookup_tag_a),
        .lookup_tag_b_i (lookup_tag_b),
        .tail_tag_o     (tail_tag),
        .full_o         (rob_full),
        .done_a_o       (rob_done_a),
        .value_a_o      (rob_value_a),
        .done_b_o       (rob_done_b),
        .value_b_o      (rob_value_b),
        .commit_valid_o (commit_valid_o),
        .commit_tag_o   (commit_tag),
        .commit_rd_o    (commit_rd_o),
        .commit_data_o  (commit_data_o)
    );

    regfile u_regfile (
        .clk            (clk),
        .reset_i        (reset_i),
        .rename_i       (rename),
        .rename_rd_i    (rd),
        .rename_tag_i   (tail_tag),
        .rs1_i          (rs1),
        .rs2_i          (rs2),
        .use_imm_i      (use_imm),
        .imm_i          (imm),
        .rob_done_a_i   (rob_done_a),
        .rob_value_a_i  (rob_value_a),
        .rob_done_b_i   (rob_done_b),
        .rob_value_b_i  (rob_value_b),
        .cdb_valid_i    (cdb_valid),
        .cdb_tag_i      (cdb_tag),
        .cdb_data_i     (cdb_data),
        .commit_valid_i (commit_valid_o),
        .commit_tag_i   (commit_tag),
        .commit_rd_i    (commit_rd_o),
        .commit_data_i  (commit_data_o),
        .lookup_tag_a_o (lookup_tag_a),
        .lookup_tag_b_o (lookup_tag_b),
        .op_a_ready_o   (op_a_ready),
        .op_a_value_o   (op_a_value),
        .op_a_tag_o     (op_a_tag),
        .op_b_ready_o   (op_b_ready),
        .op_b_value_o   (op_b_value),
        .op_b_tag_o     (op_b_tag)
    );

    // station 0 for add/sub/logic, station 1 for shifts and compares
    for (genvar s = 0; s < 2; s++) begin : g_rs
        reservation_station u_rs (
            .clk           (clk),
            .reset_i       (reset_i),
            .load_i        (rs_load[s]),
            .alu_op_i      (alu_op),
            .op_a_ready_i  (op_a_ready),
            .op_a_value_i  (op_a_value),
            .op_a_tag_i    (op_a_tag),
            .op_b_ready_i  (op_b_ready),
            .op_b_value_i  (op_b_value),
            .op_b_tag_i    (op_b_tag),
            .dest_tag_i    (tail_tag),
            .cdb_valid_i   (cdb_valid),
            .cdb_tag_i     (cdb_tag),
            .cdb_data_i    (cdb_data),
            .cdb_grant_i   (cdb_grant[s]),
            .full_o        (rs_full[s]),
            .cdb_req_o     (cdb_req[s]),
            .result_tag_o  (res_tag[s]),
            .result_data_o (res_data[s])
        );
    end

    cdb_arbiter u_cdb_arbiter (
        .clk         (clk),
        .reset_i     (reset_i),
        .req_i       (cdb_req),
        .tag_a_i     (res_tag[0]),
        .data_a_i    (res_data[0]),
        .tag_b_i     (res_tag[1]),
        .data_b_i    (res_data[1]),
        .grant_o     (cdb_grant),
        .cdb_valid_o (cdb_valid),
        .cdb_tag_o   (cdb_tag),
        .cdb_data_o  (cdb_data)
    );

endmodule

/* testbench/tb_ooo_core.sv */
`timescale 1ns/10ps
`include "tomasulo_settings.svh"

module tb_ooo_core;

    localparam int MAX_RECORDS = 64;
    localparam int REC_WORDS   = 4;

    logic             clk;
    logic             reset_i;
    logic             instr_valid_i;
    logic [31:0]      instr_i;
    logic             stall_o;
    logic             commit_valid_o;
    logic [4:0]       commit_rd_o;
    logic [`XLEN-1:0] commit_data_o;

    // four words per record: instruction, rd, value, gap
    logic [31:0] trace_mem [MAX_RECORDS*REC_WORDS];
    int          num_records;
    int          commit_cnt;
    int          err_cnt;
    int          seed;
    logic        seen_stall;

    ooo_core uut (
        .clk            (clk),
        .reset_i        (reset_i),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .stall_o        (stall_o),
        .commit_valid_o (commit_valid_o),
        .commit_rd_o    (commit_rd_o),
        .commit_data_o  (commit_data_o)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            err_cnt++;
            $display("FAILED %s: got %h, expected %h at %0t", name, actual, expected, $time);
        end
    endtask

    task automatic load_trace();
        for (int i = 0; i < MAX_RECORDS*REC_WORDS; i++)
            trace_mem[i] = '0;
        $readmemh("testbench/core_trace.txt", trace_mem);
        num_records = 0;
        // a real instruction word is never zero
        while (num_records < MAX_RECORDS && trace_mem[num_records*REC_WORDS] != 32'h0)
            num_records++;
    endtask

    // holds the instruction until an edge without stall, then idles
    task automatic issue_record(input int idx);
        logic        accepted;
        logic [31:0] rnd;
        int          gap;
        instr_valid_i = 1'b1;
        instr_i       = trace_mem[idx*REC_WORDS];
        do begin
            @(negedge clk);
            accepted = !stall_o;
            @(posedge clk);
            #1;
        end while (!accepted);
        instr_valid_i = 1'b0;
        gap = int'(trace_mem[idx*REC_WORDS+3]);
        if (trace_mem[idx*REC_WORDS+3] == 32'hff) begin
            rnd = $random(seed);
            gap = int'(rnd[1:0]);
        end
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // commit monitor, sampled mid-cycle
    //////////////////////////////////////////////////////////////////////
    always @(negedge clk) begin
        if (!reset_i) begin
            if (stall_o)
                seen_stall = 1'b1;
            if (commit_valid_o) begin
                if (commit_cnt < num_records) begin
                    check_value("commit_rd_o", 32'(commit_rd_o),
                                trace_mem[commit_cnt*REC_WORDS+1]);
                    check_value("commit_data_o", commit_data_o,
                                trace_mem[commit_cnt*REC_WORDS+2]);
                end else begin
                    err_cnt++;
                    $display("ERROR: extra commit to x%0d after the last record", commit_rd_o);
                end
                commit_cnt++;
            end
        end
    end

    initial begin
        seed          = 32'ha384;
        reset_i       = 1'b1;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        err_cnt       = 0;
        commit_cnt    = 0;
        seen_stall    = 1'b0;
        load_trace();
        repeat (4) @(posedge clk);
        #1;
        reset_i = 1'b0;
        // idle core, nothing should move
        repeat (5) begin
            @(negedge clk);
            check_value("stall_o", 32'(stall_o), 32'h0);
            check_value("commit_valid_o", 32'(commit_valid_o), 32'h0);
        end
        @(posedge clk);
        #1;
        if (num_records == 0) begin
            err_cnt++;
            $display("ERROR: the trace file holds no records");
        end
        for (int r = 0; r < num_records; r++)
            issue_record(r);
        while (commit_cnt < num_records)
            @(posedge clk);
        // a few more cycles to catch stray commits
        repeat (10) @(posedge clk);
        if (!seen_stall) begin
            err_cnt++;
            $display("ERROR: stall_o never rose during the back-to-back bursts");
        end
        $display("errors: %0d, commits: %0d of %0d", err_cnt, commit_cnt, num_records);
        if (err_cnt == 0 && commit_cnt == num_records)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    // watchdog, scaled by the trace length
    initial begin
        @(negedge reset_i);
        repeat (num_records * 20 + 100) @(posedge clk);
        $display("ERROR: timeout with %0d of %0d commits seen", commit_cnt, num_records);
        $display("Result: FAILED");
        $finish;
    end

endmodule

/* testbench/core_trace.txt */
// columns: instruction word, expected rd, expected commit value, idle gap cycles
// a gap of ff draws a random gap of 0 to 3 cycles
00500093 01 00000005 ff
ffd00113 02 fffffffd ff
0f006193 03 000000f0 ff
00200213 04 00000002 ff
003082b3 05 000000f5 00
40208333 06 00000008 00
004193b3 07 000003c0 00
00112433 08 00000001 00
001134b3 09 00000000 00
0011c533 0a 000000f5 00
004155b3 0b 3fffffff 00
40415633 0c ffffffff 00
0040e6b3 0d 00000007 00
0021f733 0e 000000f0 00
00170793 0f 000000f1 00
00f787b3 0f 000001e2 00
00379813 10 00000f10 00
40f808b3 11 00000d2e 00
40115913 12 fffffffe 00
00708013 00 0000000c 02
001009b3 13 00000005 ff
00100c93 19 00000001 00
001c9c93 19 00000002 00
001c9c93 19 00000004 00
001c9c93 19 00000008 00
001c9c93 19 00000010 00
001c9c93 19 00000020 00
001c9c93 19 00000040 00
001c9c93 19 00000080 00
001c9c93 19 00000100 00
001c9c93 19 00000200 00
001c9c93 19 00000400 00
013c8d33 1a 00000405 ff

/* ooo_core.f */
+incdir+common
common/tomasulo_pkg.sv
rs/alu.sv
rs/reservation_station.sv
rob/rob.sv
src/regfile.sv
src/issue_decode.sv
src/cdb_arbiter.sv
src/ooo_core.sv
testbench/tb_ooo_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_ooo_core
RTL_TOP   ?= ooo_core
FILELIST  ?= ooo_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
